// File: common/asa_pkg.sv
`default_nettype none

package asa_pkg;

	// packet side field widths.
	localparam int packet_id_nbits = 6;       // also sets the read-count table depth.
	localparam int port_id_nbits = 4;
	localparam int buf_ptr_nbits = 10;
	localparam int packet_length_nbits = 14;
	localparam int read_count_nbits = 5;

	// log2 depths of the intake, latency and release FIFOs.
	localparam int intake_depth_bits = 4;
	localparam int latency_depth_bits = 5;
	localparam int release_depth_bits = 7;

	// back-pressure hysteresis on intake occupancy.
	localparam int bp_on_level = 10;
	localparam int bp_off_level = 6;

	typedef enum logic [1:0] {
		sweep_idle,
		sweep_clear,
		sweep_done
	} sweep_state_t;

endpackage

`default_nettype wire

// File: common/tm_pkg.sv
`default_nettype none

package tm_pkg;

	// queue hierarchy, from first level queue down to port queue.
	localparam int first_lvl_qid_nbits = 8;
	localparam int conn_id_nbits = 6;
	localparam int conn_group_id_nbits = 5;
	localparam int port_queue_id_nbits = 3;

	// which side dropped a copy.
	typedef enum logic [1:0] {
		keep,
		drop_rep,
		drop_tm
	} drop_src_t;

endpackage

`default_nettype wire

// File: source/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter int width = 8,
	parameter int depth_bits = 4
) (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input logic [width-1:0] din,
	input logic rd,
	output logic [width-1:0] dout,
	output logic empty,
	output logic [depth_bits:0] count
);

	logic [width-1:0] mem [2**depth_bits];
	logic [depth_bits-1:0] head;
	logic [depth_bits-1:0] tail;

	assign dout = mem[head]; // head entry shows without a read.
	assign empty = (count == '0);

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[tail] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (wr) begin
				tail <= tail + 1'b1;
			end
			if (rd) begin
				head <= head + 1'b1;
			end
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rep_intake/rep_intake.sv
`timescale 1ns/100ps
`default_nettype none

module rep_intake (
	input logic clk,
	input logic rst_n,
	input logic rep_enq_req,
	input logic rep_enq_drop,
	input logic rep_enq_ucast,
	input logic rep_enq_last,
	input logic [asa_pkg::packet_id_nbits-1:0] rep_enq_packet_id,
	input logic [tm_pkg::first_lvl_qid_nbits-1:0] rep_enq_qid,
	input logic [asa_pkg::port_id_nbits-1:0] rep_enq_src_port,
	input logic [asa_pkg::buf_ptr_nbits-1:0] rep_enq_buf_ptr,
	input logic [asa_pkg::packet_length_nbits-1:0] rep_enq_packet_length,
	input logic tm_asa_poll_ack,
	input logic tm_asa_poll_drop,
	input logic [tm_pkg::conn_id_nbits-1:0] tm_asa_poll_conn_id,
	input logic [tm_pkg::conn_group_id_nbits-1:0] tm_asa_poll_conn_group_id,
	input logic [tm_pkg::port_queue_id_nbits-1:0] tm_asa_poll_port_queue_id,
	input logic [asa_pkg::port_id_nbits-1:0] tm_asa_poll_port_id,
	input logic sweep_busy,
	output logic int_rep_bp,
	output logic asa_tm_poll_req,
	output logic [tm_pkg::first_lvl_qid_nbits-1:0] asa_tm_poll_qid,
	output logic [asa_pkg::port_id_nbits-1:0] asa_tm_poll_src_port,
	output logic ack_copy,
	output logic [asa_pkg::packet_id_nbits-1:0] copy_packet_id,
	output logic [tm_pkg::first_lvl_qid_nbits-1:0] copy_qid,
	output logic [asa_pkg::port_id_nbits-1:0] copy_src_port,
	output logic [asa_pkg::buf_ptr_nbits-1:0] copy_buf_ptr,
	output logic [asa_pkg::packet_length_nbits-1:0] copy_packet_length,
	output logic copy_final,
	output tm_pkg::drop_src_t copy_drop,
	output logic [tm_pkg::conn_id_nbits-1:0] copy_conn_id,
	output logic [tm_pkg::conn_group_id_nbits-1:0] copy_conn_group_id,
	output logic [tm_pkg::port_queue_id_nbits-1:0] copy_port_queue_id,
	output logic [asa_pkg::port_id_nbits-1:0] copy_dst_port
);
	import asa_pkg::*;
	import tm_pkg::*;

	// qid and source port sit on top, the poll needs them from the intake head.
	logic [first_lvl_qid_nbits+port_id_nbits+3+packet_id_nbits+buf_ptr_nbits
		+packet_length_nbits-1:0] copy_d1;
	logic [$bits(copy_d1)-1:0] intake_dout;
	logic [$bits(copy_d1)-1:0] lat_dout;
	logic [intake_depth_bits:0] intake_count;
	logic req_d1;
	logic intake_empty;
	logic intake_rd;
	logic ack_drop_d1;
	logic lat_drop;
	logic lat_ucast;
	logic lat_last;

	always_ff @(posedge clk) begin
		copy_d1 <= {rep_enq_qid, rep_enq_src_port, rep_enq_drop, rep_enq_ucast, rep_enq_last,
			rep_enq_packet_id, rep_enq_buf_ptr, rep_enq_packet_length};
		{asa_tm_poll_qid, asa_tm_poll_src_port} <=
			intake_dout[$bits(intake_dout)-1 -: first_lvl_qid_nbits+port_id_nbits];
		ack_drop_d1 <= tm_asa_poll_drop;
		copy_conn_id <= tm_asa_poll_conn_id;
		copy_conn_group_id <= tm_asa_poll_conn_group_id;
		copy_port_queue_id <= tm_asa_poll_port_queue_id;
		copy_dst_port <= tm_asa_poll_port_id;
	end

	sync_fifo #(
		.width($bits(copy_d1)),
		.depth_bits(intake_depth_bits)
	) u_intake_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr(req_d1),
		.din(copy_d1),
		.rd(intake_rd),
		.dout(intake_dout),
		.empty(intake_empty),
		.count(intake_count)
	);

	assign intake_rd = !intake_empty; // one copy per cycle, each one polled.

	// copies wait here for their ack, which come back in poll order.
	sync_fifo #(
		.width($bits(copy_d1)),
		.depth_bits(latency_depth_bits)
	) u_latency_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr(intake_rd),
		.din(intake_dout),
		.rd(ack_copy),
		.dout(lat_dout),
		.empty(),
		.count()
	);

	assign {copy_qid, copy_src_port, lat_drop, lat_ucast, lat_last, copy_packet_id,
		copy_buf_ptr, copy_packet_length} = lat_dout;
	assign copy_final = lat_ucast | lat_last;
	assign copy_drop = lat_drop ? drop_rep : (ack_drop_d1 ? drop_tm : keep);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_d1 <= 1'b0;
			ack_copy <= 1'b0;
			asa_tm_poll_req <= 1'b0;
			int_rep_bp <= 1'b1;
		end else begin
			req_d1 <= rep_enq_req;
			ack_copy <= tm_asa_poll_ack;
			asa_tm_poll_req <= intake_rd;
			if (sweep_busy || intake_count > bp_on_level) begin
				int_rep_bp <= 1'b1;
			end else if (intake_count < bp_off_level) begin
				int_rep_bp <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: read_count/read_count_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module read_count_tracker (
	input logic clk,
	input logic rst_n,
	input logic ack_copy,
	input logic [asa_pkg::packet_id_nbits-1:0] copy_packet_id,
	input logic [tm_pkg::first_lvl_qid_nbits-1:0] copy_qid,
	input logic [asa_pkg::port_id_nbits-1:0] copy_src_port,
	input logic [asa_pkg::buf_ptr_nbits-1:0] copy_buf_ptr,
	input logic [asa_pkg::packet_length_nbits-1:0] copy_packet_length,
	input logic copy_final,
	input tm_pkg::drop_src_t copy_drop,
	input logic [tm_pkg::conn_id_nbits-1:0] copy_conn_id,
	input logic [tm_pkg::conn_group_id_nbits-1:0] copy_conn_group_id,
	input logic [tm_pkg::port_queue_id_nbits-1:0] copy_port_queue_id,
	input logic [asa_pkg::port_id_nbits-1:0] copy_dst_port,
	output logic sweep_busy,
	output logic asa_tm_enq_req,
	output logic [tm_pkg::first_lvl_qid_nbits-1:0] asa_tm_enq_qid,
	output logic [tm_pkg::conn_id_nbits-1:0] asa_tm_enq_conn_id,
	output logic [tm_pkg::conn_group_id_nbits-1:0] asa_tm_enq_conn_group_id,
	output logic [tm_pkg::port_queue_id_nbits-1:0] asa_tm_enq_port_queue_id,
	output logic [asa_pkg::port_id_nbits-1:0] asa_tm_enq_src_port,
	output logic [asa_pkg::port_id_nbits-1:0] asa_tm_enq_dst_port,
	output logic [asa_pkg::buf_ptr_nbits-1:0] asa_tm_enq_buf_ptr,
	output logic [asa_pkg::packet_length_nbits-1:0] asa_tm_enq_packet_length,
	output logic rel_push,
	output logic [asa_pkg::read_count_nbits-1:0] rel_count,
	output logic [asa_pkg::port_id_nbits-1:0] rel_port,
	output logic [asa_pkg::buf_ptr_nbits-1:0] rel_buf_ptr,
	output logic [asa_pkg::packet_length_nbits-1:0] rel_packet_length
);
	import asa_pkg::*;
	import tm_pkg::*;

	logic [read_count_nbits-1:0] rc_table [2**packet_id_nbits];
	sweep_state_t sweep_state;
	logic [packet_id_nbits-1:0] sweep_addr;

	// stage 1, one cycle after the table read.
	logic s1_valid;
	logic s1_final;
	drop_src_t s1_drop;
	logic [packet_id_nbits-1:0] s1_id;
	logic [read_count_nbits-1:0] s1_rdata;
	logic [first_lvl_qid_nbits-1:0] s1_qid;
	logic [conn_id_nbits-1:0] s1_conn_id;
	logic [conn_group_id_nbits-1:0] s1_conn_group_id;
	logic [port_queue_id_nbits-1:0] s1_port_queue_id;
	logic [port_id_nbits-1:0] s1_src_port;
	logic [port_id_nbits-1:0] s1_dst_port;
	logic [buf_ptr_nbits-1:0] s1_buf_ptr;
	logic [packet_length_nbits-1:0] s1_packet_length;

	// write port is registered, so two writes can still be in flight.
	logic w1_wr;
	logic w2_wr;
	logic [packet_id_nbits-1:0] w1_addr;
	logic [packet_id_nbits-1:0] w2_addr;
	logic [read_count_nbits-1:0] w1_data;
	logic [read_count_nbits-1:0] w2_data;
	logic [read_count_nbits-1:0] prev_count;
	logic [read_count_nbits-1:0] new_count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sweep_state <= sweep_idle;
			sweep_addr <= '0;
		end else begin
			case (sweep_state)
				sweep_idle: sweep_state <= sweep_clear;
				sweep_clear: begin
					sweep_addr <= sweep_addr + 1'b1;
					if (&sweep_addr) begin
						sweep_state <= sweep_done;
					end
				end
				default: sweep_state <= sweep_done;
			endcase
		end
	end

	assign sweep_busy = (sweep_state != sweep_done);

	always_ff @(posedge clk) begin
		if (sweep_state == sweep_clear) begin
			rc_table[sweep_addr] <= '0;
		end else if (w1_wr) begin
			rc_table[w1_addr] <= w1_data;
		end
	end

	always_ff @(posedge clk) begin
		s1_id <= copy_packet_id;
		s1_rdata <= rc_table[copy_packet_id];
		s1_final <= copy_final;
		s1_drop <= copy_drop;
		s1_qid <= copy_qid;
		s1_conn_id <= copy_conn_id;
		s1_conn_group_id <= copy_conn_group_id;
		s1_port_queue_id <= copy_port_queue_id;
		s1_src_port <= copy_src_port;
		s1_dst_port <= copy_dst_port;
		s1_buf_ptr <= copy_buf_ptr;
		s1_packet_length <= copy_packet_length;
	end

	// newest write wins.
	assign prev_count = (w1_wr && w1_addr == s1_id) ? w1_data :
		(w2_wr && w2_addr == s1_id) ? w2_data : s1_rdata;
	assign new_count = prev_count + ((s1_drop == keep) ? 1'b1 : 1'b0);

	always_ff @(posedge clk) begin
		w1_addr <= s1_id;
		w1_data <= s1_final ? '0 : new_count; // next packet on this id starts at zero.
		w2_addr <= w1_addr;
		w2_data <= w1_data;
		asa_tm_enq_qid <= s1_qid;
		asa_tm_enq_conn_id <= s1_conn_id;
		asa_tm_enq_conn_group_id <= s1_conn_group_id;
		asa_tm_enq_port_queue_id <= s1_port_queue_id;
		asa_tm_enq_src_port <= s1_src_port;
		asa_tm_enq_dst_port <= s1_dst_port;
		asa_tm_enq_buf_ptr <= s1_buf_ptr;
		asa_tm_enq_packet_length <= s1_packet_length;
		rel_count <= new_count;
		rel_port <= s1_src_port;
		rel_buf_ptr <= s1_buf_ptr;
		rel_packet_length <= s1_packet_length;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			w1_wr <= 1'b0;
			w2_wr <= 1'b0;
			asa_tm_enq_req <= 1'b0;
			rel_push <= 1'b0;
		end else begin
			s1_valid <= ack_copy;
			w1_wr <= s1_valid;
			w2_wr <= w1_wr;
			asa_tm_enq_req <= s1_valid && s1_drop == keep;
			rel_push <= s1_valid && s1_final;
		end
	end

endmodule

`default_nettype wire

// File: source/bm_release.sv
`timescale 1ns/100ps
`default_nettype none

module bm_release (
	input logic clk,
	input logic rst_n,
	input logic rel_push,
	input logic [asa_pkg::read_count_nbits-1:0] rel_count,
	input logic [asa_pkg::port_id_nbits-1:0] rel_port,
	input logic [asa_pkg::buf_ptr_nbits-1:0] rel_buf_ptr,
	input logic [asa_pkg::packet_length_nbits-1:0] rel_packet_length,
	input logic discard_req,
	input logic [asa_pkg::packet_length_nbits-1:0] discard_packet_length,
	input logic [asa_pkg::port_id_nbits-1:0] discard_src_port,
	input logic [asa_pkg::buf_ptr_nbits-1:0] discard_buf_ptr,
	output logic asa_bm_read_count_valid,
	output logic [asa_pkg::read_count_nbits-1:0] asa_bm_read_count,
	output logic [asa_pkg::packet_length_nbits-1:0] asa_bm_packet_length,
	output logic [asa_pkg::port_id_nbits-1:0] asa_bm_rc_port_id,
	output logic [asa_pkg::buf_ptr_nbits-1:0] asa_bm_buf_ptr
);
	import asa_pkg::*;

	logic [read_count_nbits+port_id_nbits+buf_ptr_nbits+packet_length_nbits-1:0] rel_din;
	logic [$bits(rel_din)-1:0] rel_dout;
	logic rel_empty;
	logic rel_rd;
	logic discard_d1;
	logic [packet_length_nbits-1:0] discard_packet_length_d1;
	logic [port_id_nbits-1:0] discard_src_port_d1;
	logic [buf_ptr_nbits-1:0] discard_buf_ptr_d1;

	assign rel_din = {rel_count, rel_port, rel_buf_ptr, rel_packet_length};

	sync_fifo #(
		.width($bits(rel_din)),
		.depth_bits(release_depth_bits)
	) u_release_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr(rel_push),
		.din(rel_din),
		.rd(rel_rd),
		.dout(rel_dout),
		.empty(rel_empty),
		.count()
	);

	assign rel_rd = !discard_d1 && !rel_empty; // discards go first.

	always_ff @(posedge clk) begin
		discard_packet_length_d1 <= discard_packet_length;
		discard_src_port_d1 <= discard_src_port;
		discard_buf_ptr_d1 <= discard_buf_ptr;
		if (discard_d1) begin
			asa_bm_read_count <= '0;
			asa_bm_rc_port_id <= discard_src_port_d1;
			asa_bm_buf_ptr <= discard_buf_ptr_d1;
			asa_bm_packet_length <= discard_packet_length_d1;
		end else begin
			{asa_bm_read_count, asa_bm_rc_port_id, asa_bm_buf_ptr, asa_bm_packet_length} <=
				rel_dout;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			discard_d1 <= 1'b0;
			asa_bm_read_count_valid <= 1'b0;
		end else begin
			discard_d1 <= discard_req;
			asa_bm_read_count_valid <= discard_d1 || !rel_empty;
		end
	end

endmodule

`default_nettype wire

// File: source/asa_tm_interface.sv
`timescale 1ns/100ps
`default_nettype none

module asa_tm_interface (
	input logic clk,
	input logic rst_n,
	input logic rep_enq_req,
	input logic rep_enq_drop,
	input logic rep_enq_ucast,
	input logic rep_enq_last,
	input logic [asa_pkg::packet_id_nbits-1:0] rep_enq_packet_id,
	input logic [tm_pkg::first_lvl_qid_nbits-1:0] rep_enq_qid,
	input logic [asa_pkg::port_id_nbits-1:0] rep_enq_src_port,
	input logic [asa_pkg::buf_ptr_nbits-1:0] rep_enq_buf_ptr,
	input logic [asa_pkg::packet_length_nbits-1:0] rep_enq_packet_length,
	input logic tm_asa_poll_ack,
	input logic tm_asa_poll_drop,
	input logic [tm_pkg::conn_id_nbits-1:0] tm_asa_poll_conn_id,
	input logic [tm_pkg::conn_group_id_nbits-1:0] tm_asa_poll_conn_group_id,
	input logic [tm_pkg::port_queue_id_nbits-1:0] tm_asa_poll_port_queue_id,
	input logic [asa_pkg::port_id_nbits-1:0] tm_asa_poll_port_id,
	input logic discard_req,
	input logic [asa_pkg::packet_length_nbits-1:0] discard_packet_length,
	input logic [asa_pkg::port_id_nbits-1:0] discard_src_port,
	input logic [asa_pkg::buf_ptr_nbits-1:0] discard_buf_ptr,
	output logic int_rep_bp,
	output logic asa_tm_poll_req,
	output logic [tm_pkg::first_lvl_qid_nbits-1:0] asa_tm_poll_qid,
	output logic [asa_pkg::port_id_nbits-1:0] asa_tm_poll_src_port,
	output logic asa_tm_enq_req,
	output logic [tm_pkg::first_lvl_qid_nbits-1:0] asa_tm_enq_qid,
	output logic [tm_pkg::conn_id_nbits-1:0] asa_tm_enq_conn_id,
	output logic [tm_pkg::conn_group_id_nbits-1:0] asa_tm_enq_conn_group_id,
	output logic [tm_pkg::port_queue_id_nbits-1:0] asa_tm_enq_port_queue_id,
	output logic [asa_pkg::port_id_nbits-1:0] asa_tm_enq_src_port,
	output logic [asa_pkg::port_id_nbits-1:0] asa_tm_enq_dst_port,
	output logic [asa_pkg::buf_ptr_nbits-1:0] asa_tm_enq_buf_ptr,
	output logic [asa_pkg::packet_length_nbits-1:0] asa_tm_enq_packet_length,
	output logic asa_bm_read_count_valid,
	output logic [asa_pkg::read_count_nbits-1:0] asa_bm_read_count,
	output logic [asa_pkg::packet_length_nbits-1:0] asa_bm_packet_length,
	output logic [asa_pkg::port_id_nbits-1:0] asa_bm_rc_port_id,
	output logic [asa_pkg::buf_ptr_nbits-1:0] asa_bm_buf_ptr
);
	import asa_pkg::*;
	import tm_pkg::*;

	// acknowledged copy, intake to tracker.
	logic ack_copy;
	logic [packet_id_nbits-1:0] copy_packet_id;
	logic [first_lvl_qid_nbits-1:0] copy_qid;
	logic [port_id_nbits-1:0] copy_src_port;
	logic [buf_ptr_nbits-1:0] copy_buf_ptr;
	logic [packet_length_nbits-1:0] copy_packet_length;
	logic copy_final;
	drop_src_t copy_drop;
	logic [conn_id_nbits-1:0] copy_conn_id;
	logic [conn_group_id_nbits-1:0] copy_conn_group_id;
	logic [port_queue_id_nbits-1:0] copy_port_queue_id;
	logic [port_id_nbits-1:0] copy_dst_port;
	logic sweep_busy;

	// final read count, tracker to release.
	logic rel_push;
	logic [read_count_nbits-1:0] rel_count;
	logic [port_id_nbits-1:0] rel_port;
	logic [buf_ptr_nbits-1:0] rel_buf_ptr;
	logic [packet_length_nbits-1:0] rel_packet_length;

	// all ports connect by name.
	rep_intake u_rep_intake (.*);

	read_count_tracker u_read_count_tracker (.*);

	bm_release u_bm_release (.*);

endmodule

`default_nettype wire

// File: bench/asa_tm_interface_props.sv
`timescale 1ns/100ps
`default_nettype none

module asa_tm_interface_props (
	input logic clk,
	input logic rst_n,
	input logic sweep_busy,
	input logic int_rep_bp,
	input logic tm_asa_poll_ack,
	input logic asa_tm_enq_req,
	input logic discard_req,
	input logic asa_bm_read_count_valid,
	input logic [asa_pkg::read_count_nbits-1:0] asa_bm_read_count
);

	int unsigned enq_total;
	int unsigned released_total;

	// running totals of TM enqueues and of the read counts handed back.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enq_total <= 0;
			released_total <= 0;
		end else begin
			if (asa_tm_enq_req) begin
				enq_total <= enq_total + 1;
			end
			if (asa_bm_read_count_valid) begin
				released_total <= released_total + asa_bm_read_count;
			end
		end
	end

	enq_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
		asa_tm_enq_req |-> $past(tm_asa_poll_ack, 3))
		else $error("TM enqueue without an ack three cycles before");

	discard_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$past(discard_req, 2) |-> asa_bm_read_count_valid)
		else $error("no buffer release two cycles after a discard");

	bp_in_sweep: assert property (@(posedge clk) disable iff (!rst_n)
		sweep_busy |-> int_rep_bp)
		else $error("back-pressure low while the table is swept");

	// released counts never cover more copies than the TM took
	count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		released_total <= enq_total)
		else $error("read counts released exceed the TM enqueues");

endmodule

bind asa_tm_interface asa_tm_interface_props u_asa_tm_interface_props (
	.clk(clk),
	.rst_n(rst_n),
	.sweep_busy(sweep_busy),
	.int_rep_bp(int_rep_bp),
	.tm_asa_poll_ack(tm_asa_poll_ack),
	.asa_tm_enq_req(asa_tm_enq_req),
	.discard_req(discard_req),
	.asa_bm_read_count_valid(asa_bm_read_count_valid),
	.asa_bm_read_count(asa_bm_read_count)
);

`default_nettype wire

// File: bench/tb_asa_tm_interface.sv
`timescale 1ns/100ps
`default_nettype none

module tb_asa_tm_interface;
	import asa_pkg::*;
	import tm_pkg::*;

	localparam int n_fields = 10;
	localparam int max_tests = 32;

	typedef struct packed {
		logic [first_lvl_qid_nbits-1:0] qid;
		logic [port_id_nbits-1:0] src_port;
		logic [buf_ptr_nbits-1:0] buf_ptr;
		logic [packet_length_nbits-1:0] len;
		logic rep_drop;
		logic tm_drop;
	} copy_rec_t;

	typedef struct packed {
		logic [first_lvl_qid_nbits-1:0] qid;
		logic [conn_id_nbits-1:0] conn_id;
		logic [conn_group_id_nbits-1:0] group_id;
		logic [port_queue_id_nbits-1:0] pq_id;
		logic [port_id_nbits-1:0] src_port;
		logic [port_id_nbits-1:0] dst_port;
		logic [buf_ptr_nbits-1:0] buf_ptr;
		logic [packet_length_nbits-1:0] len;
	} enq_rec_t;

	typedef struct packed {
		logic [read_count_nbits-1:0] count;
		logic [port_id_nbits-1:0] port;
		logic [buf_ptr_nbits-1:0] buf_ptr;
		logic [packet_length_nbits-1:0] len;
	} rel_rec_t;

	logic clk;
	logic rst_n;
	logic rep_enq_req, rep_enq_drop, rep_enq_ucast, rep_enq_last;
	logic [packet_id_nbits-1:0] rep_enq_packet_id;
	logic [first_lvl_qid_nbits-1:0] rep_enq_qid, asa_tm_poll_qid, asa_tm_enq_qid;
	logic [port_id_nbits-1:0] rep_enq_src_port, tm_asa_poll_port_id, discard_src_port;
	logic [port_id_nbits-1:0] asa_tm_poll_src_port, asa_tm_enq_src_port, asa_tm_enq_dst_port;
	logic [port_id_nbits-1:0] asa_bm_rc_port_id;
	logic [buf_ptr_nbits-1:0] rep_enq_buf_ptr, discard_buf_ptr;
	logic [buf_ptr_nbits-1:0] asa_tm_enq_buf_ptr, asa_bm_buf_ptr;
	logic [packet_length_nbits-1:0] rep_enq_packet_length, discard_packet_length;
	logic [packet_length_nbits-1:0] asa_tm_enq_packet_length, asa_bm_packet_length;
	logic tm_asa_poll_ack, tm_asa_poll_drop, discard_req;
	logic [conn_id_nbits-1:0] tm_asa_poll_conn_id, asa_tm_enq_conn_id;
	logic [conn_group_id_nbits-1:0] tm_asa_poll_conn_group_id, asa_tm_enq_conn_group_id;
	logic [port_queue_id_nbits-1:0] tm_asa_poll_port_queue_id, asa_tm_enq_port_queue_id;
	logic int_rep_bp, asa_tm_poll_req, asa_tm_enq_req, asa_bm_read_count_valid;
	logic [read_count_nbits-1:0] asa_bm_read_count;

	integer seed = 32'hd994de81;
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	int err_mark = 0;
	int limit_cycles = 0;
	int last_fire = 0;
	bit bp_fell = 1'b0;
	bit disc_v1 = 1'b0;
	bit disc_v2 = 1'b0;
	rel_rec_t disc_d1;
	rel_rec_t disc_d2;
	logic [31:0] tests [n_fields*max_tests];
	copy_rec_t poll_q[$];
	copy_rec_t ack_q[$];
	int ack_fire[$];
	enq_rec_t enq_q[$];
	rel_rec_t rel_q[$];
	int rel_test[$];

	asa_tm_interface u_asa_tm_interface (.*);

	always #50 clk = ~clk;

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s, at %0t", what, $time);
	endtask

	// TM side, acks leave in poll order after a random wait.
	always @(posedge clk) begin
		copy_rec_t rec;
		logic [31:0] r;
		#10;
		cyc = cyc + 1;
		tm_asa_poll_ack = 1'b0;
		tm_asa_poll_drop = 1'b0;
		if (ack_fire.size() > 0 && ack_fire[0] == cyc) begin
			rec = ack_q.pop_front();
			void'(ack_fire.pop_front());
			r = $random(seed);
			tm_asa_poll_ack = 1'b1;
			tm_asa_poll_drop = rec.tm_drop;
			tm_asa_poll_conn_id = r[conn_id_nbits-1:0];
			tm_asa_poll_conn_group_id = r[8 +: conn_group_id_nbits];
			tm_asa_poll_port_queue_id = r[16 +: port_queue_id_nbits];
			tm_asa_poll_port_id = r[24 +: port_id_nbits];
			if (!rec.rep_drop && !rec.tm_drop) begin
				enq_q.push_back({rec.qid, tm_asa_poll_conn_id, tm_asa_poll_conn_group_id,
					tm_asa_poll_port_queue_id, rec.src_port, tm_asa_poll_port_id,
					rec.buf_ptr, rec.len});
			end
		end
	end

	always @(negedge clk) begin
		int fire;
		int t;
		if (rst_n && !bp_fell) begin
			check_value("strobe during table sweep",
				{asa_tm_poll_req, asa_tm_enq_req, asa_bm_read_count_valid}, 0);
		end
		if (asa_tm_poll_req) begin
			if (poll_q.size() == 0) begin
				report_failure("poll request with no copy waiting for one");
			end else begin
				check_value("poll qid and source port", {asa_tm_poll_qid, asa_tm_poll_src_port},
					{poll_q[0].qid, poll_q[0].src_port});
				fire = cyc + 1 + ({$random(seed)} % 4);
				if (fire <= last_fire) begin
					fire = last_fire + 1; // acks cannot overtake each other.
				end
				last_fire = fire;
				ack_q.push_back(poll_q.pop_front());
				ack_fire.push_back(fire);
			end
		end
		if (asa_tm_enq_req) begin
			if (enq_q.size() == 0) begin
				report_failure("TM enqueue with no kept copy waiting for one");
			end else begin
				check_value("TM enqueue fields", {asa_tm_enq_qid, asa_tm_enq_conn_id,
					asa_tm_enq_conn_group_id, asa_tm_enq_port_queue_id, asa_tm_enq_src_port,
					asa_tm_enq_dst_port, asa_tm_enq_buf_ptr, asa_tm_enq_packet_length},
					enq_q.pop_front());
			end
		end
		if (disc_v2) begin
			check_value("discard release valid", asa_bm_read_count_valid, 1);
			check_value("discard release fields", {asa_bm_read_count, asa_bm_rc_port_id,
				asa_bm_buf_ptr, asa_bm_packet_length}, disc_d2);
		end else if (asa_bm_read_count_valid) begin
			if (rel_q.size() == 0) begin
				report_failure("buffer release with no packet waiting for one");
			end else begin
				check_value("packet release fields", {asa_bm_read_count, asa_bm_rc_port_id,
					asa_bm_buf_ptr, asa_bm_packet_length}, rel_q.pop_front());
				t = rel_test.pop_front();
				$display("test %0d released with read count %0d, %0d new errors", t,
					asa_bm_read_count, errors - err_mark);
				err_mark = errors;
			end
		end
		disc_v2 = disc_v1;
		disc_d2 = disc_d1;
		disc_v1 = discard_req;
		disc_d1 = {{read_count_nbits{1'b0}}, discard_src_port, discard_buf_ptr,
			discard_packet_length};
	end

	initial begin
		int n_tests;
		int n_copies;
		int base;
		int kept;
		logic [31:0] f [n_fields];
		copy_rec_t rec;
		clk = 1'b0;
		rst_n = 1'b0;
		{rep_enq_req, rep_enq_drop, rep_enq_ucast, rep_enq_last} = '0;
		rep_enq_packet_id = '0;
		rep_enq_qid = '0;
		rep_enq_src_port = '0;
		rep_enq_buf_ptr = '0;
		rep_enq_packet_length = '0;
		{tm_asa_poll_ack, tm_asa_poll_drop, tm_asa_poll_port_id} = '0;
		{tm_asa_poll_conn_id, tm_asa_poll_conn_group_id, tm_asa_poll_port_queue_id} = '0;
		{discard_req, discard_src_port, discard_buf_ptr, discard_packet_length} = '0;
		for (int i = 0; i < n_fields*max_tests; i++) begin
			tests[i] = '0;
		end
		$readmemh("bench/rep_tests.dat", tests);
		n_tests = 0;
		n_copies = 0;
		while (n_tests < max_tests && tests[n_tests*n_fields+1] != 0) begin
			n_copies += tests[n_tests*n_fields+1];
			n_tests++;
		end
		limit_cycles = 200 * n_copies + 200;
		repeat (2) @(posedge clk);
		#10 rst_n = 1'b1;
		@(negedge clk);
		check_value("back-pressure after reset", int_rep_bp, 1);
		while (int_rep_bp) @(negedge clk);
		bp_fell = 1'b1;
		for (int t = 0; t < n_tests; t++) begin
			base = t * n_fields;
			for (int k = 0; k < n_fields; k++) begin
				f[k] = tests[base+k];
			end
			kept = 0;
			for (int i = 0; i < f[1]; i++) begin
				@(posedge clk);
				#10;
				rep_enq_req = 1'b0;
				discard_req = 1'b0;
				while (int_rep_bp) begin
					@(posedge clk);
					#10;
				end
				rec.qid = f[5][first_lvl_qid_nbits-1:0] + 8'(i);
				rec.src_port = f[6][port_id_nbits-1:0];
				rec.buf_ptr = f[7][buf_ptr_nbits-1:0];
				rec.len = f[8][packet_length_nbits-1:0];
				rec.rep_drop = f[3][i];
				rec.tm_drop = f[4][i];
				poll_q.push_back(rec);
				if (!rec.rep_drop && !rec.tm_drop) begin
					kept++;
				end
				rep_enq_req = 1'b1;
				rep_enq_drop = rec.rep_drop;
				rep_enq_ucast = f[2][0];
				rep_enq_last = !f[2][0] && (i == f[1] - 1); // a unicast copy is final alone.
				rep_enq_packet_id = f[0][packet_id_nbits-1:0];
				rep_enq_qid = rec.qid;
				rep_enq_src_port = rec.src_port;
				rep_enq_buf_ptr = rec.buf_ptr;
				rep_enq_packet_length = rec.len;
				if (f[9][i]) begin
					discard_req = 1'b1;
					discard_src_port = ~rec.src_port;
					discard_buf_ptr = rec.buf_ptr + 10'h200 + 10'(i);
					discard_packet_length = rec.len + 14'(i + 1);
				end
			end
			rel_q.push_back({5'(kept), f[6][port_id_nbits-1:0], f[7][buf_ptr_nbits-1:0],
				f[8][packet_length_nbits-1:0]});
			rel_test.push_back(t);
		end
		@(posedge clk);
		#10;
		rep_enq_req = 1'b0;
		discard_req = 1'b0;
		while (poll_q.size() > 0 || ack_q.size() > 0 || enq_q.size() > 0 || rel_q.size() > 0
			|| disc_v1 || disc_v2) begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk); // stray strobes would show up here.
		$display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", limit_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/rep_tests.dat
// one test per line, hex: packet_id copies ucast rep_drop_mask tm_drop_mask qid_base
// src_port buf_ptr packet_length discard_mask, where bit i of a mask belongs to copy i
01 1 1 0000 0000 10 3 040 0040 0000
02 1 1 0000 0001 11 4 041 05dc 0000
03 1 1 0001 0000 12 5 042 0100 0000
04 4 0 0000 0000 20 1 100 0200 0000
05 4 0 0002 0000 24 2 101 0300 0000
// same packet id again, right after its release
05 3 0 0000 0004 30 2 102 0310 0000
06 8 0 0005 0040 38 6 103 0400 0000
07 10 0 0000 0000 40 7 104 0500 0000
07 2 0 0000 0000 50 7 105 0510 0000
08 6 0 0000 0000 58 8 106 0600 0015
09 1 1 0000 0000 60 9 107 0080 0001
0a 3 0 0007 0000 64 a 108 0090 0000
0b 5 0 0000 001f 68 b 109 00a0 0002
3f c 0 0081 0402 70 c 3ff 3fff 0800
00 2 0 0000 0000 80 0 000 0001 0003
10 1 1 0000 0000 90 d 200 1234 0001
10 7 0 0010 0008 98 d 201 0777 0040
11 10 0 8001 0100 a0 e 2aa 2000 ffff
12 2 0 0000 0000 b0 f 155 0abc 0000
12 1 1 0000 0000 b8 f 156 0abd 0000

// File: flist.f
common/asa_pkg.sv
common/tm_pkg.sv
source/sync_fifo.sv
rep_intake/rep_intake.sv
read_count/read_count_tracker.sv
source/bm_release.sv
source/asa_tm_interface.sv
bench/asa_tm_interface_props.sv
bench/tb_asa_tm_interface.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_asa_tm_interface -f flist.f -o tb_sim \
	|| exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qF '** PASS **' && exit 0 || exit 1
